/* design/PsramBusPkg.sv */
package PsramBusPkg;

	//------------------------------------------------------------------------
	// Bus widths
	//------------------------------------------------------------------------
	localparam int UfiDataBit          = 16;	// UFI data bus
	localparam int UsiDataBit          = 32;	// USI register data
	localparam int BusAdrsBitDefault   = 16;	// USI address width
	localparam int BlockAdrsMapDefault = 8;		// Block select field width

	typedef logic [UfiDataBit-1:0] UfiWord;
	typedef logic [UsiDataBit-1:0] UsiWord;

	//------------------------------------------------------------------------
	// Register map
	//------------------------------------------------------------------------
	// Offset field is the low nibble of the USI address
	localparam int RegOfsBit = 4;

	localparam logic [RegOfsBit-1:0] CtrlOfs = 4'h0;	// Control
	localparam logic [RegOfsBit-1:0] LatOfs  = 4'h4;	// Write latency
	localparam logic [RegOfsBit-1:0] StatOfs = 4'h8;	// Status, read only
	localparam int DropOfsBit = RegOfsBit;
	localparam logic [DropOfsBit-1:0] DropOfs = 4'hc;	// Drop counter, read only

	// Control word
	localparam int CtrlRamRstBit = 0;	// Holds memory side in reset

	// Status word
	localparam int StatInitBit = 0;
	localparam int StatBusyBit = 1;

	// Latency after reset
	localparam logic [3:0] LatDefault = 4'd4;

	// Saturating drop counter
	localparam int DropCntBit = 16;

endpackage

/* design/PsramDevPkg.sv */
package PsramDevPkg;

	//------------------------------------------------------------------------
	// Burst geometry
	//------------------------------------------------------------------------
	localparam int BurstLen    = 8;					// Words per burst, fixed
	localparam int BurstIdxBit = $clog2(BurstLen);	// Word index inside a burst
	localparam int CmdWords    = 3;					// Code, adrs high, adrs low
	localparam int LatMax      = 15;				// Largest write latency

	//------------------------------------------------------------------------
	// Device command codes
	//------------------------------------------------------------------------
	localparam logic [15:0] CmdReset = 16'h00ff;
	localparam logic [15:0] CmdWrite = 16'h0020;
	localparam logic [15:0] CmdRead  = 16'h00a0;

	//------------------------------------------------------------------------
	// Sequencer states
	//------------------------------------------------------------------------
	typedef enum logic [2:0]
	{
		Init,		// Power-up wait or held by soft reset
		RstCmd,		// Single reset command word
		Idle,
		Cmd,		// Address words of a command
		Lat,		// Write latency count
		WrData,		// Eight write words
		RdData		// Waiting on device strobes
	} SeqState;

endpackage

/* design/PsramPhy.sv */
`timescale 1ns/1ns
module PsramPhy (
	inout	logic [15:0]				sramDq,
	inout	logic [1:0]					sramDqs,
	output	logic						sramClk,
	output	logic						sramCs,
	input	PsramBusPkg::UfiWord		txWord,
	input	logic						txEn,
	input	logic						dqsEn,
	input	logic						csEn,
	output	PsramBusPkg::UfiWord		rxWord,
	output	logic						rxValid,
	input	logic						sysClk,
	input	logic						rstN
);
	import PsramBusPkg::*;

	UfiWord		txWordQ;
	logic		txEnQ;
	logic		dqsEnQ;
	logic		csEnQ;
	logic		clkEn;		// Latched while clock low
	logic		capHit;

	//------------------------------------------------------------------------
	// Output registers
	//------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		txWordQ <= txWord;
	end

	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			txEnQ  <= 1'b0;	// Pins released
			dqsEnQ <= 1'b0;
			csEnQ  <= 1'b0;	// cs high
		end
		else
		begin
			txEnQ  <= txEn;
			dqsEnQ <= dqsEn;
			csEnQ  <= csEn;
		end
	end

	// Glitch free gate on the memory clock
	always_latch
	begin
		if (!sysClk)
			clkEn <= csEnQ;
	end

	assign sramClk = sysClk & clkEn;
	assign sramCs  = !csEnQ;
	assign sramDq  = txEnQ ? txWordQ : 'z;
	assign sramDqs = dqsEnQ ? 2'b11 : 2'bzz;	// Both bytes always valid

	//------------------------------------------------------------------------
	// Read capture
	//------------------------------------------------------------------------
	// Device strobe while our drivers are off
	assign capHit = csEnQ && !txEnQ && (sramDqs == 2'b11);

	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			rxValid <= 1'b0;
		else if (capHit)
			rxValid <= 1'b1;
		else
			rxValid <= 1'b0;	// Floating strobe lands here too
	end

	always_ff @(posedge sysClk)
	begin
		if (capHit)
			rxWord <= sramDq;
	end

	// Sequencer keeps its drivers off while words come back
	assert property (@(posedge sysClk) disable iff (!rstN) rxValid |-> !txEn)
		else $error("Transmit during read capture");

endmodule

/* design/PsramWriteBuffer.sv */
`timescale 1ns/1ns
module PsramWriteBuffer (
	input	PsramBusPkg::UfiWord					ufiWd,
	input	logic [31:0]							ufiAdrs,
	input	logic									ufiWEd,
	input	logic									busy,
	output	logic									bufFull,
	output	logic [31:0]							bufBase,
	output	PsramBusPkg::UfiWord					bufWord,
	input	logic [PsramDevPkg::BurstIdxBit-1:0]	bufRdIdx,
	input	logic									bufRelease,
	output	logic									dropPulse,
	input	logic									sysClk,
	input	logic									rstN
);
	import PsramBusPkg::*;
	import PsramDevPkg::*;

	UfiWord						mem [BurstLen];
	logic [BurstIdxBit-1:0]		cnt;		// Push count of a kept or dropped burst
	logic						filling;
	logic						discarding;	// Rest of a dropped burst
	logic						burstStart;
	logic						startOk;
	logic						accept;

	assign burstStart = ufiWEd && !filling && !discarding;
	assign startOk    = !busy && !bufFull;
	assign accept     = ufiWEd && (filling || (burstStart && startOk));
	assign bufWord    = mem[bufRdIdx];	// Sequencer reads by index

	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			cnt        <= '0;
			filling    <= 1'b0;
			discarding <= 1'b0;
			bufFull    <= 1'b0;
			dropPulse  <= 1'b0;
		end
		else
		begin
			dropPulse <= burstStart && !startOk;
			if (bufRelease)
				bufFull <= 1'b0;
			if (ufiWEd)
			begin
				if (filling || discarding)
				begin
					cnt <= cnt + 1'b1;
					if (cnt == BurstIdxBit'(BurstLen - 1))
					begin
						filling    <= 1'b0;
						discarding <= 1'b0;
						bufFull    <= filling;	// Only a kept burst fills
					end
				end
				else
				begin
					cnt        <= BurstIdxBit'(1);
					filling    <= startOk;
					discarding <= !startOk;
				end
			end
		end
	end

	// Word store and base latch
	always_ff @(posedge sysClk)
	begin
		if (accept)
			mem[cnt] <= ufiWd;	// Count is zero at a burst start
		if (burstStart && startOk)
			bufBase <= {ufiAdrs[31:BurstIdxBit], {BurstIdxBit{1'b0}}};
	end

	assert property (@(posedge sysClk) disable iff (!rstN) !(bufFull && accept))
		else $error("Push accepted into a full buffer");

endmodule

/* design/PsramCsr.sv */
`timescale 1ns/1ns
module PsramCsr #(
	parameter int							pBlockAdrsMap	= PsramBusPkg::BlockAdrsMapDefault,
	parameter logic [pBlockAdrsMap-1:0]		pAdrsMap		= 'h08,
	parameter int							pBusAdrsBit		= PsramBusPkg::BusAdrsBitDefault
)(
	output	PsramBusPkg::UsiWord			usiRd,
	output	logic							usiREd,
	input	PsramBusPkg::UsiWord			usiWd,
	input	logic [pBusAdrsBit-1:0]			usiAdrs,
	input	logic							usiWCke,
	input	logic							usiRCke,
	output	logic							ramRst,
	output	logic [3:0]						latency,
	input	logic							initDone,
	input	logic							busy,
	input	logic							dropPulse,
	input	logic							sysClk,
	input	logic							rstN
);
	import PsramBusPkg::*;

	localparam logic [3:0] LatMin = 4'd2;	// Sequencer needs two cycles

	logic						blockHit;
	logic [RegOfsBit-1:0]		regOfs;
	logic [DropCntBit-1:0]		dropCnt;
	UsiWord						rdMux;

	// Upper field selects this block
	assign blockHit = (usiAdrs[pBusAdrsBit-1 -: pBlockAdrsMap] == pAdrsMap);
	assign regOfs   = usiAdrs[RegOfsBit-1:0];

	//------------------------------------------------------------------------
	// Writable registers
	//------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			ramRst  <= 1'b0;
			latency <= LatDefault;
		end
		else if (usiWCke && blockHit)
		begin
			case (regOfs)
				CtrlOfs: ramRst <= usiWd[CtrlRamRstBit];
				LatOfs:  latency <= (usiWd[3:0] < LatMin) ? LatMin : usiWd[3:0];
				default: ;	// Status and counter ignore writes
			endcase
		end
	end

	// Drop counter sticks at all ones
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			dropCnt <= '0;
		else if (dropPulse && (dropCnt != '1))
			dropCnt <= dropCnt + 1'b1;
	end

	//------------------------------------------------------------------------
	// Read path
	//------------------------------------------------------------------------
	always_comb
	begin
		rdMux = '0;
		case (regOfs)
			CtrlOfs: rdMux[CtrlRamRstBit] = ramRst;
			LatOfs:  rdMux[3:0] = latency;
			StatOfs:
			begin
				rdMux[StatInitBit] = initDone;
				rdMux[StatBusyBit] = busy;
			end
			DropOfs: rdMux[DropCntBit-1:0] = dropCnt;
			default: rdMux = '0;
		endcase
	end

	always_ff @(posedge sysClk)
	begin
		if (!rstN)
			usiREd <= 1'b0;
		else
			usiREd <= usiRCke && blockHit;	// Foreign blocks get no strobe
	end

	always_ff @(posedge sysClk)
	begin
		if (usiRCke && blockHit)
			usiRd <= rdMux;
	end

	// Bus master never overlaps read and write strobes
	assert property (@(posedge sysClk) disable iff (!rstN) !(usiWCke && usiRCke))
		else $error("USI read and write strobes together");

endmodule

/* design/PsramSequencer.sv */
`timescale 1ns/1ns
module PsramSequencer #(
	parameter int								pInitWait	= 150
)(
	input	logic								ramRst,
	input	logic [3:0]							latency,
	output	logic								initDone,
	output	logic								busy,
	input	logic								bufFull,
	input	logic [31:0]						bufBase,
	input	PsramBusPkg::UfiWord				bufWord,
	output	logic [PsramDevPkg::BurstIdxBit-1:0]	bufRdIdx,
	output	logic								bufRelease,
	input	logic								ufiRdReq,
	input	logic [31:0]						ufiRdAdrs,
	output	PsramBusPkg::UfiWord				ufiRd,
	output	logic [31:0]						ufiAdrsOut,
	output	logic								ufiREd,
	output	PsramBusPkg::UfiWord				txWord,
	output	logic								txEn,
	output	logic								dqsEn,
	output	logic								csEn,
	input	PsramBusPkg::UfiWord				rxWord,
	input	logic								rxValid,
	output	logic								rdDrop,
	input	logic								sysClk,
	input	logic								rstN
);
	import PsramDevPkg::*;

	localparam int			WaitBit     = $clog2(pInitWait + 1);
	localparam int			CsMaxCycles = CmdWords + LatMax + BurstLen;
	localparam logic [3:0]	CmdLast     = 4'(CmdWords - 1);
	localparam logic [3:0]	BurstLast   = 4'(BurstLen - 1);

	SeqState				state;
	SeqState				nextState;
	logic [3:0]				phase;		// Word or cycle within a state
	logic [WaitBit-1:0]		waitCnt;
	logic [31:0]			cmdAdrs;	// Burst base of current command
	logic					isWrite;
	logic					csEnQ;		// Mirror of the pin register
	logic					wrStart;
	logic					rdStart;

	assign wrStart  = (state == Idle) && bufFull && !ramRst;	// Writes win over reads
	assign rdStart  = (state == Idle) && !bufFull && !ramRst && !busy && ufiRdReq;
	assign rdDrop   = ufiRdReq && !rdStart;
	assign bufRdIdx = phase[BurstIdxBit-1:0];
	// Held from cs low until cs high or the last read word
	assign busy     = csEnQ || ufiREd;

	//------------------------------------------------------------------------
	// Next state and word select
	//------------------------------------------------------------------------
	always_comb
	begin
		nextState  = state;
		txWord     = '0;
		txEn       = 1'b0;
		dqsEn      = 1'b0;
		csEn       = 1'b0;
		bufRelease = 1'b0;
		case (state)
			Init:
				if (waitCnt == WaitBit'(pInitWait - 1))
					nextState = RstCmd;
			RstCmd:
			begin
				csEn      = 1'b1;
				txEn      = 1'b1;
				txWord    = CmdReset;
				nextState = Idle;
			end
			Idle:
				if (wrStart || rdStart)
				begin
					csEn      = 1'b1;	// Code word goes out at once
					txEn      = 1'b1;
					txWord    = wrStart ? CmdWrite : CmdRead;
					nextState = Cmd;
				end
			Cmd:
			begin
				csEn   = 1'b1;
				txEn   = 1'b1;
				txWord = (phase == 4'd1) ? cmdAdrs[31:16] : cmdAdrs[15:0];
				if (phase == CmdLast)
					nextState = isWrite ? Lat : RdData;	// Device times reads
			end
			Lat:
			begin
				csEn = 1'b1;
				if (phase == latency - 4'd1)
					nextState = WrData;
			end
			WrData:
			begin
				csEn   = 1'b1;
				txEn   = 1'b1;
				dqsEn  = 1'b1;
				txWord = bufWord;
				if (phase == BurstLast)
				begin
					bufRelease = 1'b1;
					nextState  = Idle;
				end
			end
			RdData:
				if (rxValid && (phase == BurstLast))
					nextState = Idle;	// Last capture lifts cs
				else
					csEn = 1'b1;
			default: nextState = Init;
		endcase
		if (ramRst)
			nextState = Init;
	end

	//------------------------------------------------------------------------
	// Control registers
	//------------------------------------------------------------------------
	always_ff @(posedge sysClk)
	begin
		if (!rstN)
		begin
			state    <= Init;
			phase    <= '0;
			waitCnt  <= '0;
			isWrite  <= 1'b0;
			initDone <= 1'b0;
			ufiREd   <= 1'b0;
			csEnQ    <= 1'b0;
		end
		else
		begin
			state <= nextState;
			if (nextState != state)
				phase <= (state == Idle) ? 4'd1 : 4'd0;
			else if ((state != RdData) || rxValid)
				phase <= phase + 4'd1;
			if ((state != Init) || ramRst)
				waitCnt <= '0;
			else
				waitCnt <= waitCnt + 1'b1;
			if (wrStart)
				isWrite <= 1'b1;
			else if (rdStart)
				isWrite <= 1'b0;
			initDone <= !((state == Init) || (state == RstCmd));	// One cycle after cs
			ufiREd   <= (state == RdData) && rxValid;
			csEnQ    <= csEn;
		end
	end

	// Command address and read return words
	always_ff @(posedge sysClk)
	begin
		if (wrStart)
			cmdAdrs <= bufBase;
		else if (rdStart)
			cmdAdrs <= {ufiRdAdrs[31:BurstIdxBit], {BurstIdxBit{1'b0}}};
		if ((state == RdData) && rxValid)
		begin
			ufiRd      <= rxWord;
			ufiAdrsOut <= cmdAdrs + 32'(phase);	// base..base+7
		end
	end

	// Chip select bounded by command, max latency and burst
	assert property (@(posedge sysClk) disable iff (!rstN)
		$rose(csEn) |-> ##[1:CsMaxCycles] !csEn)
		else $error("Chip select held too long");

endmodule

/* design/PsramBlock.sv */
`timescale 1ns/1ns
module PsramBlock #(
	parameter int								pBlockAdrsMap	= PsramBusPkg::BlockAdrsMapDefault,
	parameter logic [pBlockAdrsMap-1:0]			pAdrsMap		= 'h08,
	parameter int								pBusAdrsBit		= PsramBusPkg::BusAdrsBitDefault,
	parameter int								pInitWait		= 150
)(
	// PSRAM pins
	inout	logic [15:0]						sramDq,
	inout	logic [1:0]							sramDqs,
	output	logic								sramClk,
	output	logic								sramCs,
	// USI register slave
	output	PsramBusPkg::UsiWord				usiRd,
	output	logic								usiREd,
	input	PsramBusPkg::UsiWord				usiWd,
	input	logic [pBusAdrsBit-1:0]				usiAdrs,
	input	logic								usiWCke,
	input	logic								usiRCke,
	// UFI read return
	output	PsramBusPkg::UfiWord				ufiRd,
	output	logic [31:0]						ufiAdrsOut,
	output	logic								ufiREd,
	output	logic								ufiRVd,		// Burst in flight
	// UFI write and read request
	input	PsramBusPkg::UfiWord				ufiWd,
	input	logic [31:0]						ufiAdrs,
	input	logic								ufiWEd,
	input	logic								ufiRdReq,
	input	logic [31:0]						ufiRdAdrs,
	input	logic								sysClk,
	input	logic								rstN
);
	import PsramBusPkg::*;
	import PsramDevPkg::*;

	//------------------------------------------------------------------------
	// Internal nets
	//------------------------------------------------------------------------
	logic						ramRst;
	logic [3:0]					latency;
	logic						initDone;
	logic						busy;
	logic						bufDrop;	// From write buffer
	logic						rdDrop;		// From sequencer
	logic						dropPulse;
	logic						bufFull;
	logic [31:0]				bufBase;
	UfiWord						bufWord;
	logic [BurstIdxBit-1:0]		bufRdIdx;
	logic						bufRelease;
	UfiWord						txWord;
	logic						txEn;
	logic						dqsEn;
	logic						csEn;
	UfiWord						rxWord;
	logic						rxValid;

	assign dropPulse = bufDrop | rdDrop;	// Either side counts once
	assign ufiRVd    = busy;

	PsramCsr #(
		.pBlockAdrsMap	(pBlockAdrsMap),
		.pAdrsMap		(pAdrsMap),
		.pBusAdrsBit	(pBusAdrsBit)
	) csrUnit (
		.usiRd(usiRd), .usiREd(usiREd), .usiWd(usiWd), .usiAdrs(usiAdrs),
		.usiWCke(usiWCke), .usiRCke(usiRCke), .ramRst(ramRst), .latency(latency),
		.initDone(initDone), .busy(busy), .dropPulse(dropPulse),
		.sysClk(sysClk), .rstN(rstN)
	);

	PsramWriteBuffer wrBufUnit (
		.ufiWd(ufiWd), .ufiAdrs(ufiAdrs), .ufiWEd(ufiWEd), .busy(busy),
		.bufFull(bufFull), .bufBase(bufBase), .bufWord(bufWord), .bufRdIdx(bufRdIdx),
		.bufRelease(bufRelease), .dropPulse(bufDrop), .sysClk(sysClk), .rstN(rstN)
	);

	PsramSequencer #(
		.pInitWait		(pInitWait)
	) seqUnit (
		.ramRst(ramRst), .latency(latency), .initDone(initDone), .busy(busy),
		.bufFull(bufFull), .bufBase(bufBase), .bufWord(bufWord), .bufRdIdx(bufRdIdx),
		.bufRelease(bufRelease), .ufiRdReq(ufiRdReq), .ufiRdAdrs(ufiRdAdrs),
		.ufiRd(ufiRd), .ufiAdrsOut(ufiAdrsOut), .ufiREd(ufiREd), .txWord(txWord),
		.txEn(txEn), .dqsEn(dqsEn), .csEn(csEn), .rxWord(rxWord), .rxValid(rxValid),
		.rdDrop(rdDrop), .sysClk(sysClk), .rstN(rstN)
	);

	PsramPhy phyUnit (
		.sramDq(sramDq), .sramDqs(sramDqs), .sramClk(sramClk), .sramCs(sramCs),
		.txWord(txWord), .txEn(txEn), .dqsEn(dqsEn), .csEn(csEn),
		.rxWord(rxWord), .rxValid(rxValid), .sysClk(sysClk), .rstN(rstN)
	);

endmodule

/* verif/PsramModel.sv */
`timescale 1ns/1ns
module PsramModel (
	inout	wire [15:0]		sramDq,
	inout	wire [1:0]		sramDqs,
	input	wire			sramClk,
	input	wire			sramCs,
	input	int				rdLat,		// Cycles before the first read word
	output	int				resetCount,	// Reset commands seen so far
	output	int				lastGap		// Cycles from adrs low to first write word
);
	import PsramDevPkg::*;

	logic [15:0]	mem [int unsigned];	// Sparse device array
	int				wordIdx;			// Word number since cs fell
	logic [15:0]	code;
	logic [31:0]	adrs;
	int				gapCnt;
	int				dataCnt;
	int				latCnt;
	logic			drvEn;
	logic [15:0]	drvWord;

	assign sramDq  = drvEn ? drvWord : 16'bz;
	assign sramDqs = drvEn ? 2'b11 : 2'bzz;	// Both bytes with each word

	initial
	begin
		resetCount = 0;
		lastGap    = -1;
		wordIdx    = 0;
		drvEn      = 1'b0;
		drvWord    = '0;
	end

	// End of a command frame
	always @(posedge sramCs)
	begin
		wordIdx = 0;
		drvEn   <= 1'b0;
	end

	//------------------------------------------------------------------------
	// Command decode and data phases
	//------------------------------------------------------------------------
	always @(posedge sramClk)
	begin
		if (sramCs === 1'b0)	// Skips the unknown first clock
		begin
			if (wordIdx == 0)
			begin
				code    = sramDq;
				gapCnt  = 0;
				dataCnt = 0;
				latCnt  = 0;
				if (code == CmdReset)
				begin
					resetCount++;
					$display("PSRAM model: reset command at %0t", $time);
				end
			end
			else if (wordIdx == 1)
				adrs[31:16] = sramDq;
			else if (wordIdx == 2)
				adrs[15:0] = sramDq;
			else if (code == CmdWrite)
			begin
				if (sramDqs === 2'b11)
				begin
					if (dataCnt == 0)
					begin
						lastGap = gapCnt;
						$display("PSRAM model: write gap %0d cycles", gapCnt);
					end
					mem[adrs + dataCnt] = sramDq;
					dataCnt++;
				end
				else if (dataCnt == 0)
					gapCnt++;	// Still in latency
			end
			else if (code == CmdRead)
			begin
				if (latCnt < rdLat)
					latCnt++;
				else if (dataCnt < BurstLen)
				begin
					drvEn   <= 1'b1;
					drvWord <= mem.exists(adrs + dataCnt) ? mem[adrs + dataCnt] : 16'h0000;
					dataCnt++;
				end
				else
					drvEn <= 1'b0;	// Burst done, release pins
			end
			wordIdx++;
		end
	end

endmodule

/* verif/PsramTb.sv */
`timescale 1ns/1ns
module PsramTb;
	import PsramBusPkg::*;
	import PsramDevPkg::*;

	localparam int			ClkPeriod  = 8;
	localparam int			InitWaitTb = 20;
	localparam logic [7:0]	BlockSel   = 8'h08;
	localparam int			NumBursts  = 6;
	localparam int			NumTests   = NumBursts + 6;
	localparam int			MaxBurst   = CmdWords + LatMax + BurstLen;
	localparam int			ModelRdLat = 3;
	// Generous per test budget in clock cycles
	localparam int			WatchdogNs = (InitWaitTb * 8 + NumTests * MaxBurst * 8) * ClkPeriod;

	wire [15:0]		sramDq;
	wire [1:0]		sramDqs;
	logic			sramClk;
	logic			sramCs;
	UsiWord			usiRd;
	logic			usiREd;
	UsiWord			usiWd;
	logic [15:0]	usiAdrs;
	logic			usiWCke;
	logic			usiRCke;
	UfiWord			ufiRd;
	logic [31:0]	ufiAdrsOut;
	logic			ufiREd;
	logic			ufiRVd;
	UfiWord			ufiWd;
	logic [31:0]	ufiAdrs;
	logic			ufiWEd;
	logic			ufiRdReq;
	logic [31:0]	ufiRdAdrs;
	logic			sysClk;
	logic			rstN;

	int				resetCount;
	int				lastGap;
	int				seed;
	int				dropTally;					// Expected drop count
	UfiWord			refMem [int unsigned];		// Reference memory
	logic [31:0]	bases [NumBursts];

	PsramBlock #(
		.pBlockAdrsMap	(8),
		.pAdrsMap		(BlockSel),
		.pBusAdrsBit	(16),
		.pInitWait		(InitWaitTb)
	) dut (
		.sramDq(sramDq), .sramDqs(sramDqs), .sramClk(sramClk), .sramCs(sramCs),
		.usiRd(usiRd), .usiREd(usiREd), .usiWd(usiWd), .usiAdrs(usiAdrs),
		.usiWCke(usiWCke), .usiRCke(usiRCke), .ufiRd(ufiRd), .ufiAdrsOut(ufiAdrsOut),
		.ufiREd(ufiREd), .ufiRVd(ufiRVd), .ufiWd(ufiWd), .ufiAdrs(ufiAdrs),
		.ufiWEd(ufiWEd), .ufiRdReq(ufiRdReq), .ufiRdAdrs(ufiRdAdrs),
		.sysClk(sysClk), .rstN(rstN)
	);

	PsramModel ramModel (
		.sramDq(sramDq), .sramDqs(sramDqs), .sramClk(sramClk), .sramCs(sramCs),
		.rdLat(ModelRdLat), .resetCount(resetCount), .lastGap(lastGap)
	);

	initial
	begin
		sysClk = 1'b0;
		forever
			#(ClkPeriod / 2) sysClk = !sysClk;
	end

	// Watchdog
	initial
	begin
		#(WatchdogNs);
		$display("Timeout: the run did not finish within %0d ns", WatchdogNs);
		$display("Test FAILED");
		$fatal(1);
	end

	//------------------------------------------------------------------------
	// Compare tasks
	//------------------------------------------------------------------------
	task automatic reportError(input string msg);
		$display("[ERROR] %0t: %s", $time, msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic checkUsi(input UsiWord got, input UsiWord exp, input string what);
		if (got !== exp)
			reportError($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	task automatic checkUfi(input UfiWord got, input logic [31:0] gotAdrs,
		input UfiWord exp, input logic [31:0] expAdrs);
		if ((got !== exp) || (gotAdrs !== expAdrs))
			reportError($sformatf("UFI read: got %h at %h, expected %h at %h",
				got, gotAdrs, exp, expAdrs));
	endtask

	task automatic checkCount(input int got, input int exp, input string what);
		if (got != exp)
			reportError($sformatf("%s: got %0d, expected %0d", what, got, exp));
	endtask

	//------------------------------------------------------------------------
	// Bus tasks entered and left at a falling edge
	//------------------------------------------------------------------------
	task automatic usiWrite(input logic [7:0] blk, input logic [7:0] ofs, input UsiWord data);
		usiAdrs = {blk, ofs};
		usiWd   = data;
		usiWCke = 1'b1;
		@(negedge sysClk);
		usiWCke = 1'b0;
	endtask

	task automatic usiRead(input logic [7:0] ofs, output UsiWord data);
		usiAdrs = {BlockSel, ofs};
		usiRCke = 1'b1;
		@(negedge sysClk);
		usiRCke = 1'b0;
		if (usiREd !== 1'b1)
			reportError("USI read returned no read strobe");
		data = usiRd;
	endtask

	task automatic waitRvd(input logic level);
		while (ufiRVd !== level)
			@(negedge sysClk);
	endtask

	task automatic waitResets(input int n);
		while (resetCount < n)
			@(negedge sysClk);
	endtask

	task automatic ufiWriteBurst(input logic [31:0] base, input bit keep);
		for (int i = 0; i < BurstLen; i++)
		begin
			ufiWEd  = 1'b1;
			ufiWd   = UfiWord'($random(seed));
			ufiAdrs = base + i;
			if (keep)
				refMem[base + i] = ufiWd;	// Dropped bursts leave memory alone
			@(negedge sysClk);
		end
		ufiWEd = 1'b0;
	endtask

	task automatic sendReadReq(input logic [31:0] adrs);
		ufiRdReq  = 1'b1;
		ufiRdAdrs = adrs;
		@(negedge sysClk);
		ufiRdReq = 1'b0;
	endtask

	task automatic readBurstCheck(input logic [31:0] base);
		int got;
		got = 0;
		sendReadReq(base | (32'($random(seed)) & 32'h7));	// Low bits ignored
		while (got < BurstLen)
		begin
			if (ufiREd)
			begin
				checkUfi(ufiRd, ufiAdrsOut, refMem[base + got], base + got);
				got++;
			end
			@(negedge sysClk);
		end
		waitRvd(1'b0);
	endtask

	//------------------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------------------
	initial
	begin
		UsiWord		rd;
		int			lat;
		seed      = 23;
		dropTally = 0;
		rstN      = 1'b0;
		usiWd     = '0;
		usiAdrs   = '0;
		usiWCke   = 1'b0;
		usiRCke   = 1'b0;
		ufiWd     = '0;
		ufiAdrs   = '0;
		ufiWEd    = 1'b0;
		ufiRdReq  = 1'b0;
		ufiRdAdrs = '0;
		repeat (16)
			@(negedge sysClk);
		rstN = 1'b1;

		// Reset and init
		checkCount(int'(sramCs), 1, "sramCs after reset");
		checkCount(int'(ufiRVd), 0, "ufiRVd after reset");
		usiRead(StatOfs, rd);
		checkCount(resetCount, 0, "reset commands before init");
		checkUsi(rd, 32'h0, "status before init");
		waitResets(1);
		usiRead(StatOfs, rd);
		checkUsi(rd, 32'h1, "status after init");

		// Latency register then a foreign block access
		for (int i = 0; i < 6; i++)
		begin
			lat = 2 + (($random(seed) & 32'h7fff_ffff) % 14);
			usiWrite(BlockSel, LatOfs, UsiWord'(lat));
			usiRead(LatOfs, rd);
			checkUsi(rd, UsiWord'(lat), "latency readback");
		end
		usiAdrs = {8'h09, 8'(StatOfs)};
		usiRCke = 1'b1;
		@(negedge sysClk);
		usiRCke = 1'b0;
		checkCount(int'(usiREd), 0, "strobe for foreign block");

		// Write bursts at random latencies followed by read back
		for (int b = 0; b < NumBursts; b++)
		begin
			lat      = 2 + (($random(seed) & 32'h7fff_ffff) % 14);
			bases[b] = 32'h0001_0000 + (b * 64 + (($random(seed) & 32'h7fff) % 8)) * 8;
			usiWrite(BlockSel, LatOfs, UsiWord'(lat));
			ufiWriteBurst(bases[b], 1'b1);
			waitRvd(1'b1);
			usiRead(StatOfs, rd);
			checkUsi(rd, 32'h3, "status while busy");	// Init and busy both set
			waitRvd(1'b0);
			checkCount(lastGap, lat, "write latency gap");
		end
		for (int b = 0; b < NumBursts; b++)
			readBurstCheck(bases[b]);

		// Requests while a burst is in flight
		ufiWriteBurst(bases[1] + 32'h100, 1'b1);
		waitRvd(1'b1);
		sendReadReq(bases[0]);
		dropTally++;
		ufiWriteBurst(bases[0], 1'b0);	// Starts while busy
		dropTally++;
		waitRvd(1'b0);
		usiRead(DropOfs, rd);
		checkUsi(rd, UsiWord'(dropTally), "drop counter");
		readBurstCheck(bases[0]);
		readBurstCheck(bases[1] + 32'h100);

		// Soft reset through the control bit
		usiWrite(BlockSel, CtrlOfs, 32'h1);
		repeat (3)
			@(negedge sysClk);
		usiRead(StatOfs, rd);
		checkUsi(rd, 32'h0, "status in soft reset");
		usiWrite(BlockSel, CtrlOfs, 32'h0);
		waitResets(2);
		usiRead(StatOfs, rd);
		checkUsi(rd, 32'h1, "status after soft reset");
		checkCount(resetCount, 2, "reset commands");

		$display("Test OK");
		$finish;
	end

endmodule

/* PsramBlock.f */
design/PsramBusPkg.sv
design/PsramDevPkg.sv
design/PsramPhy.sv
design/PsramWriteBuffer.sv
design/PsramCsr.sv
design/PsramSequencer.sv
design/PsramBlock.sv
verif/PsramModel.sv
verif/PsramTb.sv
